/* logic/cb_settings.svh */
// Screen geometry and field widths for the console buffer, included by the package and RTL
`ifndef CB_SETTINGS_SVH
`define CB_SETTINGS_SVH

// Text layout
`define CB_COLS        16
`define CB_ROWS        4
`define CB_FONT_HEIGHT 2   // Scan lines per text row

`define CB_CELLS       (`CB_COLS * `CB_ROWS)

// Field widths
`define CB_ADDR_W      6   // Must cover CB_CELLS
`define CB_CHAR_W      8
`define CB_TAB_W       3

`endif

/* logic/cb_pkg.sv */
// Shared types of the console buffer, referenced by scoped name from every RTL file
`include "cb_settings.svh"

package cb_pkg;

  typedef logic [`CB_CHAR_W-1:0] char_t;
  typedef logic [`CB_ADDR_W-1:0] cell_addr_t;
  typedef logic [`CB_TAB_W-1:0]  tab_count_t;

  // Codes the writer acts on, NUL doubles as the blank cell
  typedef enum logic [7:0] {
    CC_NUL = 8'h00,
    CC_HT  = 8'h09,
    CC_LF  = 8'h0a,
    CC_CR  = 8'h0d
  } ctrl_code_e;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_PUT_CHAR,
    WR_FILL_LINE,  // Blanks to end of line for CR and LF
    WR_FILL_TAB,
    WR_CLEAR
  } writer_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_WRITER,
    RD_ISSUE,
    RD_DATA        // Drain of the read pipe
  } reader_state_e;

endpackage

/* logic/cb_mem_if.sv */
// Screen memory port bundle shared by the writer, the store and the frame reader
interface cb_mem_if;

  // Write side, one cell per cycle
  logic               wr_en;
  cb_pkg::cell_addr_t wr_addr;
  cb_pkg::char_t      wr_data;

  // Read side, data one cycle after address
  cb_pkg::cell_addr_t rd_addr;
  cb_pkg::char_t      rd_data;

  modport writer (
    output wr_en, wr_addr, wr_data
  );

  modport reader (
    output rd_addr,
    input  rd_data
  );

  modport store (
    input  wr_en, wr_addr, wr_data, rd_addr,
    output rd_data
  );

endinterface

/* logic/char_writer.sv */
// Input side of the console buffer, decodes characters and writes them at the cursor
`include "cb_settings.svh"

module char_writer (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_char_stb,
  input  cb_pkg::char_t      i_char,
  input  logic               i_alt_func_en,
  input  cb_pkg::tab_count_t i_tab_count,
  input  logic               i_clear_screen_stb,
  input  logic               i_frame_busy,
  output logic               o_wr_char_rdy,
  output logic               o_clear_screen,
  output logic               o_writer_busy,
  cb_mem_if.writer           mem
);

  localparam cb_pkg::cell_addr_t LAST_CELL = cb_pkg::cell_addr_t'(`CB_CELLS - 1);
  localparam cb_pkg::cell_addr_t LAST_ROW  = cb_pkg::cell_addr_t'(`CB_CELLS - `CB_COLS);
  localparam cb_pkg::cell_addr_t ROW_STEP  = cb_pkg::cell_addr_t'(`CB_COLS);

  cb_pkg::writer_state_e state;
  cb_pkg::cell_addr_t    cursor;
  cb_pkg::cell_addr_t    line_start;       // First cell of the cursor's row
  cb_pkg::cell_addr_t    next_cursor;
  cb_pkg::cell_addr_t    next_line_start;
  cb_pkg::char_t         r_char;
  cb_pkg::tab_count_t    tab_left;
  logic                  clear_req;
  logic                  sweep_done;
  logic                  take;
  logic                  at_line_end;
  logic                  printable;

  assign take        = i_char_stb && o_wr_char_rdy;
  assign at_line_end = (cursor == line_start + ROW_STEP - 1'b1);
  assign printable   = (i_char >= 8'h20) && (i_char != 8'h7f);  // DEL counts as control

  // A pending clear holds off new characters
  assign o_wr_char_rdy  = (state == cb_pkg::WR_IDLE) && !clear_req;
  assign o_clear_screen = (state == cb_pkg::WR_CLEAR);
  assign o_writer_busy  = (state != cb_pkg::WR_IDLE);

  assign mem.wr_addr = cursor;
  assign mem.wr_data = (state == cb_pkg::WR_PUT_CHAR) ? r_char
                                                       : cb_pkg::char_t'(cb_pkg::CC_NUL);

  always_comb begin
    case (state)
      cb_pkg::WR_PUT_CHAR,
      cb_pkg::WR_FILL_LINE: mem.wr_en = 1'b1;
      cb_pkg::WR_FILL_TAB:  mem.wr_en = (tab_left != '0);
      cb_pkg::WR_CLEAR:     mem.wr_en = !sweep_done;
      default:              mem.wr_en = 1'b0;
    endcase
  end

  // Cursor step with wrap, row start follows when the row is left
  always_comb begin
    next_cursor     = (cursor == LAST_CELL) ? '0 : cursor + 1'b1;
    next_line_start = line_start;
    if (at_line_end) begin
      next_line_start = (line_start == LAST_ROW) ? '0 : line_start + ROW_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= cb_pkg::WR_CLEAR;  // Screen is wiped after reset
      cursor     <= '0;
      line_start <= '0;
      tab_left   <= '0;
      clear_req  <= 1'b0;
      sweep_done <= 1'b0;
    end else begin
      case (state)
        cb_pkg::WR_IDLE: begin
          if (clear_req && !i_frame_busy) begin
            clear_req  <= 1'b0;
            cursor     <= '0;
            line_start <= '0;
            sweep_done <= 1'b0;
            state      <= cb_pkg::WR_CLEAR;
          end else if (take) begin
            if (i_alt_func_en) begin
              state <= cb_pkg::WR_PUT_CHAR;  // Any code stored as a glyph
            end else begin
              case (i_char)
                cb_pkg::CC_HT: begin
                  tab_left <= i_tab_count;
                  state    <= cb_pkg::WR_FILL_TAB;
                end
                cb_pkg::CC_LF,
                cb_pkg::CC_CR: state <= cb_pkg::WR_FILL_LINE;
                default: begin
                  if (printable) begin
                    state <= cb_pkg::WR_PUT_CHAR;
                  end
                end
              endcase
            end
          end
        end
        cb_pkg::WR_PUT_CHAR: begin
          cursor     <= next_cursor;
          line_start <= next_line_start;
          state      <= cb_pkg::WR_IDLE;
        end
        cb_pkg::WR_FILL_LINE: begin
          cursor     <= next_cursor;
          line_start <= next_line_start;
          if (at_line_end) begin
            state <= cb_pkg::WR_IDLE;  // Cursor now at start of next row
          end
        end
        cb_pkg::WR_FILL_TAB: begin
          if (tab_left == '0) begin
            state <= cb_pkg::WR_IDLE;
          end else begin
            cursor     <= next_cursor;
            line_start <= next_line_start;
            tab_left   <= tab_left - 1'b1;
          end
        end
        cb_pkg::WR_CLEAR: begin
          // One extra cycle after the last cell before going idle
          if (sweep_done) begin
            state <= cb_pkg::WR_IDLE;
          end else begin
            cursor     <= next_cursor;
            sweep_done <= (cursor == LAST_CELL);
          end
        end
        default: state <= cb_pkg::WR_IDLE;
      endcase

      if (i_clear_screen_stb) begin
        clear_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      r_char <= i_char;
    end
  end

endmodule

/* logic/char_store.sv */
// Screen memory of the console buffer, one write port and a registered read port
`include "cb_settings.svh"

module char_store (
  input logic     clk,
  cb_mem_if.store mem
);

  // One character per screen cell
  cb_pkg::char_t cells [`CB_CELLS];

  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      cells[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Read data lags the address by one cycle
  always_ff @(posedge clk) begin
    mem.rd_data <= cells[mem.rd_addr];
  end

endmodule

/* logic/frame_reader.sv */
// Output side of the console buffer, streams the screen once per font scan line of each row
`include "cb_settings.svh"

module frame_reader (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_read_frame_stb,
  input  logic          i_char_req_en,
  input  logic          i_writer_busy,
  output logic          o_frame_busy,
  output logic          o_char_rdy,
  output cb_pkg::char_t o_char,
  cb_mem_if.reader      mem
);

  localparam int COL_W  = $clog2(`CB_COLS);
  localparam int LINE_W = (`CB_FONT_HEIGHT > 1) ? $clog2(`CB_FONT_HEIGHT) : 1;

  localparam logic [COL_W-1:0]   LAST_COL  = COL_W'(`CB_COLS - 1);
  localparam logic [LINE_W-1:0]  LAST_LINE = LINE_W'(`CB_FONT_HEIGHT - 1);
  localparam cb_pkg::cell_addr_t LAST_ROW  = cb_pkg::cell_addr_t'(`CB_CELLS - `CB_COLS);
  localparam cb_pkg::cell_addr_t ROW_STEP  = cb_pkg::cell_addr_t'(`CB_COLS);

  cb_pkg::reader_state_e state;
  logic [COL_W-1:0]      col;
  logic [LINE_W-1:0]     line;
  cb_pkg::cell_addr_t    row_base;
  logic                  issue;
  logic                  valid_d1;  // Read in flight inside the store

  assign issue        = (state == cb_pkg::RD_ISSUE) && i_char_req_en;
  assign o_frame_busy = (state != cb_pkg::RD_IDLE);
  assign mem.rd_addr  = row_base + cb_pkg::cell_addr_t'(col);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= cb_pkg::RD_IDLE;
      col      <= '0;
      line     <= '0;
      row_base <= '0;
    end else begin
      case (state)
        cb_pkg::RD_IDLE: begin
          if (i_read_frame_stb) begin
            state <= cb_pkg::RD_WAIT_WRITER;
          end
        end
        cb_pkg::RD_WAIT_WRITER: begin
          if (!i_writer_busy) begin
            col      <= '0;
            line     <= '0;
            row_base <= '0;  // Frame always starts at cell 0
            state    <= cb_pkg::RD_ISSUE;
          end
        end
        cb_pkg::RD_ISSUE: begin
          if (i_char_req_en) begin
            if (col != LAST_COL) begin
              col <= col + 1'b1;
            end else begin
              col <= '0;
              if (line != LAST_LINE) begin
                line <= line + 1'b1;  // Same row again for the next scan line
              end else begin
                line <= '0;
                if (row_base == LAST_ROW) begin
                  state <= cb_pkg::RD_DATA;
                end else begin
                  row_base <= row_base + ROW_STEP;
                end
              end
            end
          end
        end
        cb_pkg::RD_DATA: begin
          if (!valid_d1) begin
            state <= cb_pkg::RD_IDLE;  // Last character leaves this cycle
          end
        end
        default: state <= cb_pkg::RD_IDLE;
      endcase
    end
  end

  // Issue, then store read, then output register
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_d1   <= 1'b0;
      o_char_rdy <= 1'b0;
    end else begin
      valid_d1   <= issue;
      o_char_rdy <= valid_d1;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_d1) begin
      o_char <= mem.rd_data;
    end
  end

endmodule

/* logic/console_buffer.sv */
// Top level of the console buffer, joins writer, screen store and frame reader
module console_buffer (
  input  logic               clk,
  input  logic               rst,

  // Character input
  input  logic               i_char_stb,
  input  cb_pkg::char_t      i_char,
  input  logic               i_alt_func_en,
  input  cb_pkg::tab_count_t i_tab_count,
  input  logic               i_clear_screen_stb,
  output logic               o_wr_char_rdy,
  output logic               o_clear_screen,

  // Frame output
  input  logic               i_read_frame_stb,
  input  logic               i_char_req_en,
  output logic               o_char_rdy,
  output cb_pkg::char_t      o_char
);

  logic writer_busy;
  logic frame_busy;

  cb_mem_if u_mem_if ();

  char_writer u_char_writer (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_tab_count        (i_tab_count),
    .i_clear_screen_stb (i_clear_screen_stb),
    .i_frame_busy       (frame_busy),
    .o_wr_char_rdy      (o_wr_char_rdy),
    .o_clear_screen     (o_clear_screen),
    .o_writer_busy      (writer_busy),
    .mem                (u_mem_if.writer)
  );

  char_store u_char_store (
    .clk (clk),
    .mem (u_mem_if.store)
  );

  frame_reader u_frame_reader (
    .clk              (clk),
    .rst              (rst),
    .i_read_frame_stb (i_read_frame_stb),
    .i_char_req_en    (i_char_req_en),
    .i_writer_busy    (writer_busy),
    .o_frame_busy     (frame_busy),
    .o_char_rdy       (o_char_rdy),
    .o_char           (o_char),
    .mem              (u_mem_if.reader)
  );

endmodule

/* tests/cb_checks.svh */
// Compare tasks and result counters of the console buffer testbench, included in its module body
`ifndef CB_CHECKS_SVH
`define CB_CHECKS_SVH

  int n_checks = 0;
  int n_errors = 0;

  // One screen character against its expected code
  task automatic check_char(input cb_pkg::char_t got, input cb_pkg::char_t exp,
                            input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  // Counts, lengths and latencies
  task automatic check_count(input int got, input int exp, input string what);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

`endif

/* tests/console_buffer_tb.sv */
// Self-checking testbench of the console buffer, replays tests/cb_stim.txt against a screen model
`include "cb_settings.svh"

module console_buffer_tb;

  localparam int FRAME_LEN = `CB_ROWS * `CB_FONT_HEIGHT * `CB_COLS;
  localparam int CLEAR_LEN = `CB_CELLS + 1;

  logic               clk;
  logic               rst;
  logic               i_char_stb;
  cb_pkg::char_t      i_char;
  logic               i_alt_func_en;
  cb_pkg::tab_count_t i_tab_count;
  logic               i_clear_screen_stb;
  logic               i_read_frame_stb;
  logic               i_char_req_en;
  logic               o_wr_char_rdy;
  logic               o_clear_screen;
  logic               o_char_rdy;
  cb_pkg::char_t      o_char;

  cb_pkg::char_t         screen [`CB_CELLS];  // Reference screen
  int                    cursor;
  int                    seed = 32'h6e6f7e7f;
  int                    cycle_cnt = 0;
  int                    cycle_limit = 0;
  int                    n_tests = 0;
  byte                   cmd_op [$];
  int                    cmd_val [$];
  int                    cmd_alt [$];
  int                    cmd_cnt [$];
  logic [8*`CB_COLS-1:0] img_rows [$];        // Expected rows, column 0 leftmost

  `include "cb_checks.svh"

  console_buffer u_console_buffer (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_tab_count        (i_tab_count),
    .i_clear_screen_stb (i_clear_screen_stb),
    .o_wr_char_rdy      (o_wr_char_rdy),
    .o_clear_screen     (o_clear_screen),
    .i_read_frame_stb   (i_read_frame_stb),
    .i_char_req_en      (i_char_req_en),
    .o_char_rdy         (o_char_rdy),
    .o_char             (o_char)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_limit != 0);
    wait (cycle_cnt >= cycle_limit);
    $display("Run stopped after %0d cycles, the DUT stopped responding", cycle_cnt);
    $display("sim failed");
    $finish;
  end

  function automatic void model_step();
    cursor = (cursor + 1) % `CB_CELLS;
  endfunction

  // Screen rules for one accepted code
  function automatic void model_write(input cb_pkg::char_t c, input logic alt, input int cnt);
    logic last;
    if (alt || (c >= 8'h20 && c != 8'h7f)) begin
      screen[cursor] = c;
      model_step();
    end else if (c == 8'h0d || c == 8'h0a) begin
      do begin
        last = (cursor % `CB_COLS) == (`CB_COLS - 1);
        screen[cursor] = 8'h00;
        model_step();
      end while (!last);
    end else if (c == 8'h09) begin
      repeat (cnt) begin
        screen[cursor] = 8'h00;
        model_step();
      end
    end
  endfunction

  task automatic load_stim();
    int    fd;
    string line;
    byte   op;
    int    v;
    int    a;
    int    n;
    logic [8*`CB_COLS-1:0] row;
    fd = $fopen("tests/cb_stim.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("Could not open the stimulus file tests/cb_stim.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        op = line.getc(0);
        if (op == "R") begin
          void'($sscanf(line, "R %h", row));
          img_rows.push_back(row);
        end else if (op == "C" || op == "N" || op == "K" || op == "F") begin
          void'($sscanf(line, "%c %h %h %h", op, v, a, n));
          cmd_op.push_back(op);
          cmd_val.push_back(v);
          cmd_alt.push_back(a);
          cmd_cnt.push_back(n);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_char(input cb_pkg::char_t c, input logic alt, input cb_pkg::tab_count_t n);
    int   lat;
    logic is_ctrl;
    is_ctrl = (c == 8'h09) || (c == 8'h0a) || (c == 8'h0d);
    while (!o_wr_char_rdy) @(negedge clk);
    i_char_stb    = 1'b1;
    i_char        = c;
    i_alt_func_en = alt;
    i_tab_count   = n;
    @(negedge clk);
    i_char_stb = 1'b0;
    lat = 1;
    while (!o_wr_char_rdy) begin
      @(negedge clk);
      lat++;
    end
    if (alt || (c >= 8'h20 && c != 8'h7f)) begin
      check_count(lat, 2, "ready latency of a character");
    end else if (!is_ctrl) begin
      check_count(lat, 1, "ready latency of an ignored code");  // Ready never drops
    end
    model_write(c, alt, int'(n));
  endtask

  task automatic wait_clear();
    int len;
    while (!o_clear_screen) @(negedge clk);
    len = 0;
    while (o_clear_screen) begin
      len++;
      @(negedge clk);
    end
    check_count(len, CLEAR_LEN, "clear length");
    foreach (screen[i]) screen[i] = 8'h00;
    cursor = 0;
  endtask

  // Model against the image written in the stim file
  task automatic check_image(input int frame);
    logic [8*`CB_COLS-1:0] row;
    if (img_rows.size() < (frame + 1) * `CB_ROWS) begin
      n_errors++;
      $display("Stimulus file has no expected image for frame %0d", frame);
    end else begin
      for (int r = 0; r < `CB_ROWS; r++) begin
        row = img_rows[frame * `CB_ROWS + r];
        for (int c = 0; c < `CB_COLS; c++) begin
          check_char(screen[r * `CB_COLS + c], row[8 * (`CB_COLS - c) - 1 -: 8],
                     $sformatf("model row %0d col %0d", r, c));
        end
      end
    end
  endtask

  task automatic read_frame(input logic drops);
    cb_pkg::char_t exp_q [$];
    int            got;
    int            tail;
    for (int r = 0; r < `CB_ROWS; r++) begin
      for (int l = 0; l < `CB_FONT_HEIGHT; l++) begin
        for (int c = 0; c < `CB_COLS; c++) begin
          exp_q.push_back(screen[r * `CB_COLS + c]);
        end
      end
    end
    i_read_frame_stb = 1'b1;
    @(negedge clk);
    i_read_frame_stb = 1'b0;
    got  = 0;
    tail = 0;
    while (tail < 8) begin  // Watch a few cycles past the end for extra pulses
      i_char_req_en = drops ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      if (o_char_rdy) begin
        if (got < FRAME_LEN) begin
          check_char(o_char, exp_q[got], $sformatf("frame character %0d", got));
        end
        got++;
      end
      if (got >= FRAME_LEN) tail++;
    end
    i_char_req_en = 1'b0;
    check_count(got, FRAME_LEN, "frame length");
  endtask

  initial begin
    i_char_stb         = 1'b0;
    i_char             = '0;
    i_alt_func_en      = 1'b0;
    i_tab_count        = '0;
    i_clear_screen_stb = 1'b0;
    i_read_frame_stb   = 1'b0;
    i_char_req_en      = 1'b0;
    rst                = 1'b1;
    cursor             = 0;
    load_stim();
    cycle_limit = (cmd_op.size() + 1) * (4 * FRAME_LEN + CLEAR_LEN) + 200;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_count(int'(o_clear_screen), 1, "clear flag after reset");
    check_count(int'(o_wr_char_rdy), 0, "write ready after reset");
    check_count(int'(o_char_rdy), 0, "character ready after reset");
    wait_clear();
    for (int i = 0; i < cmd_op.size(); i++) begin
      case (cmd_op[i])
        "C": send_char(cb_pkg::char_t'(cmd_val[i]), cmd_alt[i] != 0,
                       cb_pkg::tab_count_t'(cmd_cnt[i]));
        "N": begin
          for (int k = 0; k < cmd_cnt[i]; k++) begin
            send_char(cb_pkg::char_t'(cmd_val[i] + k), cmd_alt[i] != 0, '0);
          end
        end
        "K": begin
          i_clear_screen_stb = 1'b1;
          @(negedge clk);
          i_clear_screen_stb = 1'b0;
          wait_clear();
        end
        default: begin
          check_image(n_tests);
          read_frame(cmd_val[i] != 0);
          n_tests++;
          $display("Test %0d finished, errors so far %0d", n_tests, n_errors);
        end
      endcase
    end
    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+logic
+incdir+tests
logic/cb_pkg.sv
logic/cb_mem_if.sv
logic/char_writer.sv
logic/char_store.sv
logic/frame_reader.sv
logic/console_buffer.sv
tests/console_buffer_tb.sv

/* run.sh */
#!/bin/sh
# Builds the console buffer testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f all.f --top-module console_buffer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vconsole_buffer_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1

/* tests/cb_stim.txt */
# Columns: op value alt count, all hex. C one code, N count codes from value, K clear, F frame
# F value 1 drops i_char_req_en at random. The R lines after F are the rows, column 0 leftmost
F 0 0 0
R 00000000000000000000000000000000
R 00000000000000000000000000000000
R 00000000000000000000000000000000
R 00000000000000000000000000000000
N 41 0 20
C 0a 0 0
N 61 0 12
F 1 0 0
R 7172434445464748494a4b4c4d4e4f50
R 5152535455565758595a5b5c5d5e5f60
R 00000000000000000000000000000000
R 6162636465666768696a6b6c6d6e6f70
C 07 0 0
C 0d 0 0
N 31 0 3
C 0a 0 0
C 0a 0 0
C 58 0 0
C 0d 0 0
C 5a 0 0
F 0 0 0
R 5a720000000000000000000000000000
R 31323300000000000000000000000000
R 00000000000000000000000000000000
R 58000000000000000000000000000000
C 09 0 3
C 54 0 0
C 0d 1 0
C 07 1 0
C 09 0 0
C 41 0 0
F 1 0 0
R 5a000000540d07410000000000000000
R 31323300000000000000000000000000
R 00000000000000000000000000000000
R 58000000000000000000000000000000
K 0 0 0
C 42 0 0
C 43 0 0
F 1 0 0
R 42430000000000000000000000000000
R 00000000000000000000000000000000
R 00000000000000000000000000000000
R 00000000000000000000000000000000
